/* Makefile */
# Verilator build and run for the DMA latency statistics testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_stats
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Everything OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
rtl/dma_stats_pkg.sv
rtl/dma_latency_tracker.sv
rtl/dma_stats_accum.sv
rtl/dma_stats_top.sv
testbench/tb_dma_stats.sv

/* rtl/dma_latency_tracker.sv */
// same-tag start and finish in one cycle is illegal; an unstarted tag gives undefined len/latency
`timescale 1ns/1ps

module dma_latency_tracker import dma_stats_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dma_start_t  start,         // tag and length of a new transfer
    input  logic        start_valid,
    input  dma_finish_t finish,        // tag and status of a completion
    input  logic        finish_valid,
    output lat_event_t  evt,           // zero whenever event_valid is low
    output logic        event_valid
);

    localparam int depth = 2**tag_w;  // one slot per tag

    logic [lat_w-1:0] ts;                  // free-running timestamp
    logic [len_w-1:0] len_mem [depth];     // length per tag
    logic [lat_w-1:0] ts_mem  [depth];     // start timestamp per tag

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // timestamp
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin : timestamp
        if (rst) begin
            ts <= '0;
        end else begin
            ts <= ts + 1'b1;  // wraps at 2**lat_w
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tag memories written on start
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin : tag_store
        if (start_valid) begin
            len_mem[start.tag] <= start.len;
            ts_mem[start.tag]  <= ts;  // value at the sampling edge
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // event register one cycle after the finish edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin : event_reg
        if (rst) begin
            evt         <= '0;
            event_valid <= 1'b0;
        end else begin
            evt         <= '0;  // idle cycles carry zeros
            event_valid <= finish_valid;
            if (finish_valid) begin
                evt.tag     <= finish.tag;
                evt.len     <= len_mem[finish.tag];
                evt.status  <= finish.status;
                // modulo difference, so a wrapped timestamp still gives the right latency
                evt.latency <= ts - ts_mem[finish.tag];
            end
        end
    end

    // the memories have one port per direction, so a same-tag start would race the lookup
    a_no_tag_collision : assert property (
        @(posedge clk) disable iff (rst)
        !(start_valid && finish_valid && (start.tag == finish.tag))
    ) else $error("start and finish on tag 0x%0h in one cycle", start.tag);

endmodule

/* rtl/dma_stats_accum.sv */
// STAT_WIDTH must be at least len_w and lat_w; counters wrap; undefined kinds read as zero
`timescale 1ns/1ps

module dma_stats_accum import dma_stats_pkg::*; #(
    parameter int STAT_WIDTH = 32  // width of every counter
) (
    input  logic                  clk,
    input  logic                  rst,
    input  lat_event_t            rd_event,        // read channel tracker
    input  logic                  rd_event_valid,
    input  lat_event_t            wr_event,        // write channel tracker
    input  logic                  wr_event_valid,
    input  logic                  clear,           // zeroes all counters
    input  logic                  rd_en,
    input  stat_addr_t            rd_addr,
    output logic [STAT_WIDTH-1:0] rd_data,
    output logic                  rd_valid
);

    // two banks of five counters indexed by chan_e then stat_kind_e
    logic [STAT_WIDTH-1:0] cnt [num_chan][num_kind];

    // event streams indexed by chan_e
    lat_event_t ev       [num_chan];
    logic       ev_valid [num_chan];

    assign ev[ch_read]        = rd_event;
    assign ev[ch_write]       = wr_event;
    assign ev_valid[ch_read]  = rd_event_valid;
    assign ev_valid[ch_write] = wr_event_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // both banks update in the same cycle from their own streams
    always_ff @(posedge clk) begin : counters
        if (rst || clear) begin
            // an event arriving with clear is dropped
            for (int c = 0; c < num_chan; c++) begin
                for (int k = 0; k < num_kind; k++) begin
                    cnt[c][k] <= '0;
                end
            end
        end else begin
            for (int c = 0; c < num_chan; c++) begin
                if (ev_valid[c]) begin
                    cnt[c][st_ops]     <= cnt[c][st_ops] + 1'b1;
                    cnt[c][st_bytes]   <= cnt[c][st_bytes] + STAT_WIDTH'(ev[c].len);
                    cnt[c][st_lat_sum] <= cnt[c][st_lat_sum] + STAT_WIDTH'(ev[c].latency);
                    if (STAT_WIDTH'(ev[c].latency) > cnt[c][st_lat_max]) begin
                        cnt[c][st_lat_max] <= STAT_WIDTH'(ev[c].latency);  // new peak
                    end
                    if (ev[c].status != '0) begin
                        cnt[c][st_errors] <= cnt[c][st_errors] + 1'b1;
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port with one cycle latency
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin : read_valid
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // samples the counter before this edge's update or clear
    always_ff @(posedge clk) begin : read_data
        if (rd_en) begin
            if (rd_addr.kind <= st_errors) begin
                rd_data <= cnt[rd_addr.chan][rd_addr.kind];
            end else begin
                rd_data <= '0;  // slots 5..7 do not exist
            end
        end
    end

    // host must only address the five defined counters
    a_kind_defined : assert property (
        @(posedge clk) disable iff (rst)
        rd_en |-> (rd_addr.kind inside {st_ops, st_bytes, st_lat_sum, st_lat_max, st_errors})
    ) else $error("stat read of undefined kind %0d", rd_addr.kind);

endmodule

/* rtl/dma_stats_pkg.sv */
// tag_w sets the tracker memory depth (2**tag_w); timestamps and latencies wrap at 2**lat_w
package dma_stats_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int tag_w    = 8;   // transfer tag
    localparam int len_w    = 16;  // transfer length in bytes
    localparam int status_w = 4;   // completion status where 0 means ok
    localparam int lat_w    = 16;  // timestamp and latency that wrap

    localparam int num_chan = 2;   // read and write
    localparam int num_kind = 5;   // counters per channel

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // dma strobes and tracker result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [len_w-1:0] len;
    } dma_start_t;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [status_w-1:0] status;  // non-zero counts as error
    } dma_finish_t;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [len_w-1:0]    len;      // length stored at start
        logic [status_w-1:0] status;
        logic [lat_w-1:0]    latency;  // finish edge minus start edge
    } lat_event_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter addressing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {
        ch_read  = 1'b0,
        ch_write = 1'b1
    } chan_e;

    typedef enum logic [2:0] {
        st_ops     = 3'd0,  // finishes seen
        st_bytes   = 3'd1,  // sum of lengths
        st_lat_sum = 3'd2,
        st_lat_max = 3'd3,
        st_errors  = 3'd4   // finishes with non-zero status
    } stat_kind_e;

    typedef struct packed {
        chan_e      chan;
        stat_kind_e kind;
    } stat_addr_t;

endpackage

/* rtl/dma_stats_top.sv */
// no back-pressure anywhere; read latency is one cycle, finish-to-counter latency two cycles
`timescale 1ns/1ps

module dma_stats_top import dma_stats_pkg::*; #(
    parameter int STAT_WIDTH = 32  // statistics counter width
) (
    input  logic                  clk,
    input  logic                  rst,
    // read channel strobes
    input  dma_start_t            rd_start,
    input  logic                  rd_start_valid,
    input  dma_finish_t           rd_finish,
    input  logic                  rd_finish_valid,
    // write channel strobes
    input  dma_start_t            wr_start,
    input  logic                  wr_start_valid,
    input  dma_finish_t           wr_finish,
    input  logic                  wr_finish_valid,
    // host counter access
    input  logic                  stat_rd_en,
    input  stat_addr_t            stat_rd_addr,
    input  logic                  stat_clear,
    output logic [STAT_WIDTH-1:0] stat_rd_data,
    output logic                  stat_rd_valid
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trackers, one per channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    lat_event_t rd_event;        // read latency result
    logic       rd_event_valid;
    lat_event_t wr_event;        // write latency result
    logic       wr_event_valid;

    dma_latency_tracker u_rd_tracker (
        .clk          (clk),
        .rst          (rst),
        .start        (rd_start),
        .start_valid  (rd_start_valid),
        .finish       (rd_finish),
        .finish_valid (rd_finish_valid),
        .evt          (rd_event),
        .event_valid  (rd_event_valid)
    );

    dma_latency_tracker u_wr_tracker (
        .clk          (clk),
        .rst          (rst),
        .start        (wr_start),
        .start_valid  (wr_start_valid),
        .finish       (wr_finish),
        .finish_valid (wr_finish_valid),
        .evt          (wr_event),
        .event_valid  (wr_event_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared counter file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dma_stats_accum #(
        .STAT_WIDTH (STAT_WIDTH)
    ) u_accum (
        .clk            (clk),
        .rst            (rst),
        .rd_event       (rd_event),
        .rd_event_valid (rd_event_valid),
        .wr_event       (wr_event),
        .wr_event_valid (wr_event_valid),
        .clear          (stat_clear),
        .rd_en          (stat_rd_en),
        .rd_addr        (stat_rd_addr),
        .rd_data        (stat_rd_data),
        .rd_valid       (stat_rd_valid)
    );

endmodule

/* testbench/tb_dma_stats.sv */
// tags are drawn from 0..15 so they get reused; random stimulus from a galois lfsr seeded with 4
`timescale 1ns/1ps

module tb_dma_stats import dma_stats_pkg::*; ();

    localparam int STAT_WIDTH = 32;
    localparam int clk_period = 8;                 // ns
    localparam int n_mix  = 300;                   // cycles of clean mixed traffic
    localparam int n_err  = 200;                   // cycles of traffic with error statuses
    localparam int n_post = 150;                   // cycles of traffic after the clear
    localparam int total_cycles = 8 + 40 + 60 + n_mix + 40 + n_err + 80 + n_post;
    localparam int watchdog_ns  = 2 * total_cycles * clk_period;  // twice the expected run

    logic clk = 1'b0;
    logic rst;
    dma_start_t rd_start;
    dma_start_t wr_start;
    dma_finish_t rd_finish;
    dma_finish_t wr_finish;
    logic rd_start_valid;
    logic rd_finish_valid;
    logic wr_start_valid;
    logic wr_finish_valid;
    logic stat_rd_en;
    logic stat_clear;
    stat_addr_t stat_rd_addr;
    logic [STAT_WIDTH-1:0] stat_rd_data;
    logic stat_rd_valid;

    // reference state
    logic [STAT_WIDTH-1:0] exp_cnt [num_chan][num_kind];  // expected counters per bank
    bit busy [num_chan][16];                              // tag started and not yet finished
    int start_cyc [num_chan][16];                         // drive cycle of the start
    logic [len_w-1:0] len_of [num_chan][16];
    stat_addr_t addr_q [$];                               // reads in flight
    logic [STAT_WIDTH-1:0] exp_q [$];
    logic [15:0] lfsr = 16'd4;
    int cyc = 0;                                          // edges seen by the stimulus
    int errors = 0;
    int errs_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #(clk_period / 2) clk = ~clk;

    dma_stats_top #(.STAT_WIDTH(STAT_WIDTH)) DUT (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);  // taps 16,14,13,11
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);    // one step per bit
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // event the tracker must emit for a finish driven in the current cycle
    function automatic lat_event_t expect_event(input int c, input int t,
                                                input logic [status_w-1:0] st);
        lat_event_t ev;
        ev.tag     = tag_w'(t);
        ev.len     = len_of[c][t];
        ev.status  = st;
        ev.latency = lat_w'(cyc - start_cyc[c][t]);  // edges between the two samples
        return ev;
    endfunction

    // one counter after one event by the counter rules
    function automatic logic [STAT_WIDTH-1:0] next_count(input stat_kind_e kind,
            input logic [STAT_WIDTH-1:0] old, input lat_event_t ev);
        logic [STAT_WIDTH-1:0] lat;
        lat = STAT_WIDTH'(ev.latency);
        case (kind)
            st_ops:     return old + 1;
            st_bytes:   return old + STAT_WIDTH'(ev.len);
            st_lat_sum: return old + lat;
            st_lat_max: return (lat > old) ? lat : old;
            default:    return (ev.status != '0) ? old + 1 : old;  // error count
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_stat(input stat_addr_t a, input logic [STAT_WIDTH-1:0] exp,
                              input logic [STAT_WIDTH-1:0] got);
        chan_e ch;
        stat_kind_e kd;
        ch = a.chan;
        kd = a.kind;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s %s read 0x%0h, expected 0x%0h",
                     $time, ch.name(), kd.name(), got, exp);
        end
    endtask

    task automatic check_idle(input logic valid, input string what);
        if (valid !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t: %s is high while idle", $time, what);
        end
    endtask

    // read data is stable mid-cycle, so compare on the falling edge
    always @(negedge clk) begin : compare_reads
        stat_addr_t a;
        logic [STAT_WIDTH-1:0] e;
        if (stat_rd_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("stat_rd_valid went high at %0t with no read issued", $time);
            end else begin
                a = addr_q.pop_front();
                e = exp_q.pop_front();
                check_stat(a, e, stat_rd_data);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_edge();
        @(posedge clk);
        cyc++;
        rd_start_valid  <= 1'b0;  // strobes last one cycle
        rd_finish_valid <= 1'b0;
        wr_start_valid  <= 1'b0;
        wr_finish_valid <= 1'b0;
        stat_rd_en      <= 1'b0;
        stat_clear      <= 1'b0;
    endtask

    task automatic drive_start(input int c, input int t, input logic [len_w-1:0] len);
        dma_start_t s;
        s.tag = tag_w'(t);
        s.len = len;
        if (c == ch_read) begin
            rd_start <= s;
            rd_start_valid <= 1'b1;
        end else begin
            wr_start <= s;
            wr_start_valid <= 1'b1;
        end
        busy[c][t] = 1'b1;
        start_cyc[c][t] = cyc;
        len_of[c][t] = len;
    endtask

    task automatic drive_finish(input int c, input int t, input logic [status_w-1:0] st);
        dma_finish_t f;
        lat_event_t ev;
        f.tag = tag_w'(t);
        f.status = st;
        ev = expect_event(c, t, st);
        if (c == ch_read) begin
            rd_finish <= f;
            rd_finish_valid <= 1'b1;
        end else begin
            wr_finish <= f;
            wr_finish_valid <= 1'b1;
        end
        for (int k = 0; k < num_kind; k++) begin
            exp_cnt[c][k] = next_count(stat_kind_e'(k[2:0]), exp_cnt[c][k], ev);
        end
        busy[c][t] = 1'b0;
    endtask

    task automatic read_stat(input stat_addr_t a);
        stat_rd_en <= 1'b1;
        stat_rd_addr <= a;
        addr_q.push_back(a);
        exp_q.push_back(exp_cnt[a.chan][a.kind]);  // value before this edge's update
    endtask

    task automatic do_clear();
        stat_clear <= 1'b1;
        for (int c = 0; c < num_chan; c++) begin
            for (int k = 0; k < num_kind; k++) begin
                exp_cnt[c][k] = '0;
            end
        end
    endtask

    task automatic wait_reads();
        while (exp_q.size() != 0) next_edge();  // until every read has returned
    endtask

    task automatic read_all();
        stat_addr_t a;
        for (int c = 0; c < num_chan; c++) begin
            for (int k = 0; k < num_kind; k++) begin
                next_edge();
                a.chan = chan_e'(c[0]);
                a.kind = stat_kind_e'(k[2:0]);
                read_stat(a);
            end
        end
        next_edge();
        wait_reads();
    endtask

    task automatic drain();
        repeat (4) next_edge();  // finish to counter takes two edges
    endtask

    // random starts and finishes on both channels where finishes pick any open tag
    task automatic run_traffic(input int n, input bit with_errors);
        int st_tag;
        int fin_tag;
        int off;
        bit do_start;
        bit do_fin;
        logic [status_w-1:0] st;
        for (int i = 0; i < n; i++) begin
            next_edge();
            for (int c = 0; c < num_chan; c++) begin
                st_tag = int'(rand_bits(4));
                do_start = rand_bits(1) && !busy[c][st_tag];
                do_fin = 1'b0;
                fin_tag = 0;
                if (rand_bits(1) == 1) begin
                    off = int'(rand_bits(4));
                    for (int j = 0; j < 16; j++) begin
                        if (!do_fin && busy[c][(off + j) % 16]) begin
                            fin_tag = (off + j) % 16;
                            do_fin = 1'b1;
                        end
                    end
                end
                st = '0;
                if (with_errors && rand_bits(1) == 1) st = status_w'(rand_bits(status_w));
                if (do_fin) drive_finish(c, fin_tag, st);  // open tag, never the new one
                if (do_start) drive_start(c, st_tag, len_w'(rand_bits(len_w)));
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %-22s passed", name);
        end else begin
            tests_failed++;
            $display("test %-22s failed with %0d errors", name, errors - errs_at_start);
        end
        errs_at_start = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : run_tests
        stat_addr_t a;
        rst = 1'b1;
        rd_start = '0;
        wr_start = '0;
        rd_finish = '0;
        wr_finish = '0;
        rd_start_valid = 1'b0;
        rd_finish_valid = 1'b0;
        wr_start_valid = 1'b0;
        wr_finish_valid = 1'b0;
        stat_rd_en = 1'b0;
        stat_clear = 1'b0;
        stat_rd_addr = '0;
        for (int c = 0; c < num_chan; c++) begin
            for (int k = 0; k < num_kind; k++) exp_cnt[c][k] = '0;
            for (int t = 0; t < 16; t++) busy[c][t] = 1'b0;
        end
        repeat (8) next_edge();
        rst <= 1'b0;
        @(negedge clk);
        check_idle(stat_rd_valid, "stat_rd_valid");
        check_idle(DUT.rd_event_valid, "read event_valid");
        check_idle(DUT.wr_event_valid, "write event_valid");
        read_all();
        finish_test("reset state");

        next_edge();
        drive_start(ch_read, 5, 16'h0123);
        repeat (13) next_edge();                  // latency of 13 edges
        drive_finish(ch_read, 5, '0);
        drain();
        read_all();
        finish_test("single read transfer");

        run_traffic(n_mix, 1'b0);
        drain();
        read_all();
        finish_test("interleaved traffic");

        run_traffic(n_err, 1'b1);
        drain();
        read_all();
        finish_test("error counting");

        next_edge();
        a.chan = ch_write;
        a.kind = st_bytes;
        read_stat(a);                             // same edge as the clear sees old value
        do_clear();
        next_edge();
        wait_reads();
        read_all();
        run_traffic(n_post, 1'b1);
        drain();
        read_all();
        finish_test("clear");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: the run did not end within %0d ns", watchdog_ns);
        $display("Something failed");
        $finish;
    end

endmodule
